//--- run.sh
#!/bin/sh
# Build and run the DMA controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -f sources.f --top-module dmaTb -o simDma
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/simDma > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
  echo "no result line in sim.log"
  exit 1
fi
exit 0

//--- sources.f
+incdir+verilog
verilog/dmaPkg.sv
verilog/dmaIfs.sv
verilog/timingAndControl.sv
verilog/priorityLogic.sv
verilog/dmaRegisters.sv
verilog/dmaController.sv
testbench/dmaClockGen.sv
testbench/dmaChecker.sv
testbench/dmaTb.sv

//--- testbench/dmaChecker.sv
`timescale 1ns/1ps
`include "dmaCtl_defs.svh"

module dmaChecker
(
  input  logic                     TCcpuIf,
  input  logic                     rstN,
  input  logic                     csN,
  input  logic                     wrN,
  input  logic [3:0]               cpuAddr,
  input  logic [`DMA_DATA_W-1:0]   cpuData,
  input  logic [`DMA_CHANNELS-1:0] dreq,
  input  logic                     hrq,
  input  logic                     aen,
  input  logic                     adstb,
  input  logic [`DMA_CHANNELS-1:0] dack,
  input  logic [`DMA_ADDR_W-1:0]   dmaAddr,
  input  logic                     memrN,
  input  logic                     memwN,
  input  logic                     iorN,
  input  logic                     iowN,
  input  logic                     eopN,
  input  int                       testNum,
  input  logic                     testEnd,
  output int                       errCount,
  output int                       xferCount
);

  // Reference model of the programmed state
  logic [15:0] baseAddr [4];
  logic [15:0] curAddr [4];
  logic [15:0] baseCount [4];
  logic [15:0] curCount [4];
  logic [7:0]  modeByte [4];
  logic [3:0]  mask;
  logic        rotate;
  logic        bytePtr;
  logic [1:0]  topPrio;
  logic [3:0]  lastReq;
  logic        prevHrq;
  int          phase;
  int          resetCycles = 0;
  int          testErrs = 0;
  int          testXfers = 0;
  logic [1:0]  xChan;
  logic        xTc;
  // Order is memrN, memwN, iorN, iowN
  logic [3:0]  expStrobe;

  initial
  begin
    errCount  = 0;
    xferCount = 0;
  end

  task automatic compareValue(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got)
    begin
      $display("error: %s expected %h got %h at %0t", name, exp, got, $time);
      errCount++;
      testErrs++;
    end
  endtask

  task automatic reportProblem(input string what);
    $display("%s at %0t", what, $time);
    errCount++;
    testErrs++;
  endtask

  // First requesting channel found when searching upward from the top slot
  function automatic logic [1:0] pickChan(input logic [3:0] req, input logic [1:0] first);
    logic [1:0] idx;
    logic [1:0] pick;
    logic       found;
    pick  = first;
    found = 1'b0;
    for (int i = 0; i < 4; i++)
    begin
      idx = first + 2'(i);
      if (!found && req[idx])
      begin
        pick  = idx;
        found = 1'b1;
      end
    end
    return pick;
  endfunction

  always @(posedge TCcpuIf)
  begin : watchDut
    logic [3:0] strobes;
    logic [3:0] pendingReq;
    logic [1:0] ch;
    strobes    = {memrN, memwN, iorN, iowN};
    pendingReq = dreq & ~mask;
    if (!rstN)
    begin
      mask    = 4'hF;
      rotate  = 1'b0;
      bytePtr = 1'b0;
      topPrio = 2'd0;
      phase   = 0;
      lastReq = 4'h0;
      prevHrq = 1'b0;
      if (resetCycles > 1)
      begin
        compareValue("hrq", 32'(1'b0), 32'(hrq));
        compareValue("aen", 32'(1'b0), 32'(aen));
        compareValue("adstb", 32'(1'b0), 32'(adstb));
        compareValue("dack", 32'(4'h0), 32'(dack));
        compareValue("strobes", 32'(4'hF), 32'(strobes));
        compareValue("eopN", 32'(1'b1), 32'(eopN));
      end
      resetCycles++;
    end
    else
    begin
      if (hrq && !prevHrq && lastReq == 4'h0)
        reportProblem("hrq raised with no unmasked request pending");

      if (phase > 0)
      begin
        compareValue("dack", 32'(4'b1 << xChan), 32'(dack));
        compareValue("aen", 32'(1'b1), 32'(aen));
        compareValue("hrq", 32'(1'b1), 32'(hrq));
        compareValue("adstb", 32'(1'b0), 32'(adstb));
        compareValue("dmaAddr", 32'(curAddr[xChan]), 32'(dmaAddr));
        case (phase)
          1, 2:
          begin
            compareValue("strobes", 32'(expStrobe), 32'(strobes));
            compareValue("eopN", 32'(1'b1), 32'(eopN));
          end
          3:
          begin
            compareValue("strobes", 32'(4'hF), 32'(strobes));
            compareValue("eopN", 32'(!xTc), 32'(eopN));
            if (xTc && modeByte[xChan][4])
            begin
              curAddr[xChan]  = baseAddr[xChan];
              curCount[xChan] = baseCount[xChan];
            end
            else
            begin
              curAddr[xChan]  = modeByte[xChan][5] ? curAddr[xChan] - 16'd1
                                                   : curAddr[xChan] + 16'd1;
              curCount[xChan] = curCount[xChan] - 16'd1;
              if (xTc)
                mask[xChan] = 1'b1;
            end
            topPrio = xChan + 2'd1;
          end
          default: ;
        endcase
        phase = (phase == 3) ? 0 : phase + 1;
        if (phase == 0)
          phase = -1;
      end
      else if (phase == -1)
        phase = 0;

      // Idle cycle right after S4
      if (phase == 0 && !adstb && prevHrq && !hrq)
      begin
        compareValue("dack", 32'(4'h0), 32'(dack));
        compareValue("aen", 32'(1'b0), 32'(aen));
      end

      if (adstb)
      begin
        if (lastReq == 4'h0)
          reportProblem("transfer started with no unmasked request");
        xChan = pickChan(lastReq, rotate ? topPrio : 2'd0);
        compareValue("dack", 32'(4'b1 << xChan), 32'(dack));
        compareValue("dmaAddr", 32'(curAddr[xChan]), 32'(dmaAddr));
        compareValue("aen", 32'(1'b1), 32'(aen));
        compareValue("strobes", 32'(4'hF), 32'(strobes));
        compareValue("eopN", 32'(1'b1), 32'(eopN));
        xTc = curCount[xChan] == 16'd0;
        case (modeByte[xChan][3:2])
          2'd1: expStrobe = 4'b1001;
          2'd2: expStrobe = 4'b0110;
          default: expStrobe = 4'b1111;
        endcase
        phase = 1;
        xferCount++;
        testXfers++;
      end

      if (!csN && !wrN)
      begin
        ch = cpuAddr[2:1];
        if (!cpuAddr[3])
        begin
          if (cpuAddr[0])
          begin
            if (bytePtr)
              baseCount[ch][15:8] = cpuData;
            else
              baseCount[ch][7:0] = cpuData;
            curCount[ch] = baseCount[ch];
          end
          else
          begin
            if (bytePtr)
              baseAddr[ch][15:8] = cpuData;
            else
              baseAddr[ch][7:0] = cpuData;
            curAddr[ch] = baseAddr[ch];
          end
          bytePtr = !bytePtr;
        end
        else if (cpuAddr == `DMA_REG_CMD)
          rotate = cpuData[4];
        else if (cpuAddr == `DMA_REG_MASK)
          mask[cpuData[1:0]] = cpuData[2];
        else if (cpuAddr == `DMA_REG_MODE)
          modeByte[cpuData[1:0]] = cpuData;
        else if (cpuAddr == `DMA_REG_CLRFF)
          bytePtr = 1'b0;
      end

      lastReq = pendingReq;
      prevHrq = hrq;

      if (testEnd)
      begin
        $display("test %0d: %0d transfers, %0d errors", testNum, testXfers, testErrs);
        testXfers = 0;
        testErrs  = 0;
      end
    end
  end

endmodule

//--- testbench/dmaClockGen.sv
`timescale 1ns/1ps

module dmaClockGen
(
  output logic TCcpuIf,
  output logic rstN
);

  initial
  begin
    TCcpuIf = 1'b0;
    forever #5 TCcpuIf = ~TCcpuIf;
  end

  initial
  begin
    rstN = 1'b0;
    repeat (10) @(posedge TCcpuIf);
    rstN <= 1'b1;
  end

endmodule

//--- testbench/dmaTb.sv
`timescale 1ns/1ps
`include "dmaCtl_defs.svh"

module dmaTb;

  typedef struct packed {
    logic [7:0]  modeBits;
    logic        rotate;
    logic [15:0] startAddr;
    logic [15:0] count;
    logic [3:0]  lines;
    logic [7:0]  xfers;
  } testRowT;

  localparam int NumRows = 6;

  logic        TCcpuIf;
  logic        rstN;
  logic        csN;
  logic        wrN;
  logic [3:0]  cpuAddr;
  logic [7:0]  cpuData;
  logic [3:0]  dreq;
  logic        hlda = 1'b0;
  logic        hrq;
  logic        aen;
  logic        adstb;
  logic [3:0]  dack;
  logic [15:0] dmaAddr;
  logic        memrN;
  logic        memwN;
  logic        iorN;
  logic        iowN;
  logic        eopN;
  int          testNum;
  logic        testEnd;
  int          errCount;
  int          xferCount;
  testRowT     rows [NumRows];
  int          limit = 0;
  int          cycleCount = 0;
  logic [31:0] rngState = 32'h7bcd_f85d;
  logic [1:0]  holdDelay = 2'd0;
  logic        holdArmed = 1'b0;

  dmaClockGen clkGen (
    .TCcpuIf (TCcpuIf),
    .rstN    (rstN)
  );

  dmaController uut (
    .TCcpuIf (TCcpuIf),
    .rstN    (rstN),
    .csN     (csN),
    .wrN     (wrN),
    .cpuAddr (cpuAddr),
    .cpuData (cpuData),
    .dreq    (dreq),
    .hlda    (hlda),
    .hrq     (hrq),
    .aen     (aen),
    .adstb   (adstb),
    .dack    (dack),
    .dmaAddr (dmaAddr),
    .memrN   (memrN),
    .memwN   (memwN),
    .iorN    (iorN),
    .iowN    (iowN),
    .eopN    (eopN)
  );

  dmaChecker dutMonitor (
    .TCcpuIf   (TCcpuIf),
    .rstN      (rstN),
    .csN       (csN),
    .wrN       (wrN),
    .cpuAddr   (cpuAddr),
    .cpuData   (cpuData),
    .dreq      (dreq),
    .hrq       (hrq),
    .aen       (aen),
    .adstb     (adstb),
    .dack      (dack),
    .dmaAddr   (dmaAddr),
    .memrN     (memrN),
    .memwN     (memwN),
    .iorN      (iorN),
    .iowN      (iowN),
    .eopN      (eopN),
    .testNum   (testNum),
    .testEnd   (testEnd),
    .errCount  (errCount),
    .xferCount (xferCount)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic int countLines(input logic [3:0] lines);
    int n;
    n = 0;
    for (int i = 0; i < 4; i++)
      n += int'(lines[i]);
    return n;
  endfunction

  // Mode byte holds type in 3:2, autoInit in 4 and decrement in 5
  task automatic loadTable();
    rows[0] = '{8'h04, 1'b0, 16'h1000, 16'd3, 4'b0001, 8'd4};
    rows[1] = '{8'h28, 1'b0, 16'h2001, 16'd2, 4'b0100, 8'd3};
    rows[2] = '{8'h00, 1'b0, 16'h30ff, 16'd1, 4'b1000, 8'd2};
    rows[3] = '{8'h14, 1'b0, 16'h40fe, 16'd1, 4'b0010, 8'd5};
    rows[4] = '{8'h08, 1'b0, 16'h5000, 16'd2, 4'b1111, 8'd3};
    rows[5] = '{8'h04, 1'b1, 16'h6000, 16'd2, 4'b1111, 8'd3};
  endtask

  task automatic writeReg(input logic [3:0] addr, input logic [7:0] data);
    @(posedge TCcpuIf);
    csN     <= 1'b0;
    wrN     <= 1'b0;
    cpuAddr <= addr;
    cpuData <= data;
  endtask

  task automatic releaseBus();
    @(posedge TCcpuIf);
    csN <= 1'b1;
    wrN <= 1'b1;
  endtask

  task automatic programRow(input testRowT row);
    logic [15:0] addr;
    for (int c = 0; c < 4; c++)
      writeReg(`DMA_REG_MASK, 8'h04 | 8'(c));
    writeReg(`DMA_REG_CLRFF, 8'h00);
    writeReg(`DMA_REG_CMD, {3'b000, row.rotate, 4'h0});
    for (int c = 0; c < 4; c++)
    begin
      addr = row.startAddr + 16'(c * 256);
      writeReg(`DMA_REG_MODE, row.modeBits | 8'(c));
      writeReg(4'(2 * c), addr[7:0]);
      writeReg(4'(2 * c), addr[15:8]);
      writeReg(4'(2 * c + 1), row.count[7:0]);
      writeReg(4'(2 * c + 1), row.count[15:8]);
    end
    for (int c = 0; c < 4; c++)
      if (row.lines[c])
        writeReg(`DMA_REG_MASK, 8'(c));
    releaseBus();
  endtask

  task automatic endTest();
    @(posedge TCcpuIf);
    testEnd <= 1'b1;
    @(posedge TCcpuIf);
    testEnd <= 1'b0;
  endtask

  task automatic runRow(input testRowT row);
    int chanDone [4];
    int done;
    int want;
    done = 0;
    want = countLines(row.lines) * int'(row.xfers);
    for (int c = 0; c < 4; c++)
      chanDone[c] = 0;
    programRow(row);
    @(posedge TCcpuIf);
    dreq <= row.lines;
    while (done < want)
    begin
      @(posedge TCcpuIf);
      if (adstb)
        for (int c = 0; c < 4; c++)
          if (dack[c])
          begin
            chanDone[c]++;
            done++;
            if (chanDone[c] == int'(row.xfers))
              dreq[c] <= 1'b0;
          end
    end
    while (hrq || aen)
      @(posedge TCcpuIf);
    // Channels that hit terminal count are masked and must stay quiet
    if (!row.modeBits[4])
    begin
      dreq <= row.lines;
      repeat (8) @(posedge TCcpuIf);
      dreq <= 4'h0;
    end
  endtask

  // Bus grant answers hrq after 0 to 3 extra cycles
  always @(posedge TCcpuIf)
  begin : answerHold
    logic [31:0] nextRng;
    if (!rstN || !hrq)
    begin
      hlda      <= 1'b0;
      holdArmed <= 1'b0;
    end
    else if (!hlda)
    begin
      if (!holdArmed)
      begin
        nextRng = xorshift(rngState);
        rngState  <= nextRng;
        holdDelay <= nextRng[1:0];
        holdArmed <= 1'b1;
      end
      else if (holdDelay == 2'd0)
        hlda <= 1'b1;
      else
        holdDelay <= holdDelay - 2'd1;
    end
  end

  always @(posedge TCcpuIf)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= limit)
    begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  initial
  begin
    csN     = 1'b1;
    wrN     = 1'b1;
    cpuAddr = 4'h0;
    cpuData = 8'h00;
    dreq    = 4'h0;
    testNum = 0;
    testEnd = 1'b0;
    loadTable();
    limit = 200;
    for (int r = 0; r < NumRows; r++)
      limit += countLines(rows[r].lines) * int'(rows[r].xfers) * 10 + 40;

    @(posedge TCcpuIf);
    while (!rstN)
      @(posedge TCcpuIf);

    // All channels still masked after reset
    dreq <= 4'hF;
    repeat (8) @(posedge TCcpuIf);
    dreq <= 4'h0;
    endTest();

    for (int r = 0; r < NumRows; r++)
    begin
      testNum <= r + 1;
      runRow(rows[r]);
      endTest();
    end

    repeat (4) @(posedge TCcpuIf);
    $display("tests %0d, transfers %0d, errors %0d", NumRows + 1, xferCount, errCount);
    if (errCount == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- verilog/dmaController.sv
`timescale 1ns/1ps
`include "dmaCtl_defs.svh"

module dmaController
(
  input  logic                     TCcpuIf,
  input  logic                     rstN,
  input  logic                     csN,
  input  logic                     wrN,
  input  logic [3:0]               cpuAddr,
  input  logic [`DMA_DATA_W-1:0]   cpuData,
  input  logic [`DMA_CHANNELS-1:0] dreq,
  input  logic                     hlda,
  output logic                     hrq,
  output logic                     aen,
  output logic                     adstb,
  output logic [`DMA_CHANNELS-1:0] dack,
  output logic [`DMA_ADDR_W-1:0]   dmaAddr,
  output logic                     memrN,
  output logic                     memwN,
  output logic                     iorN,
  output logic                     iowN,
  output logic                     eopN
);

  dmaSigIf sigIf ();
  dmaRegIf regIf ();

  timingAndControl tcCtl (
    .TCcpuIf (TCcpuIf),
    .rstN    (rstN),
    .hlda    (hlda),
    .sig     (sigIf.control),
    .regs    (regIf.control),
    .hrq     (hrq),
    .aen     (aen),
    .adstb   (adstb),
    .memrN   (memrN),
    .memwN   (memwN),
    .iorN    (iorN),
    .iowN    (iowN),
    .eopN    (eopN)
  );

  priorityLogic prioLogic (
    .TCcpuIf (TCcpuIf),
    .rstN    (rstN),
    .dreq    (dreq),
    .sig     (sigIf.prio),
    .regs    (regIf.prio),
    .dack    (dack)
  );

  dmaRegisters regFile (
    .TCcpuIf (TCcpuIf),
    .rstN    (rstN),
    .csN     (csN),
    .wrN     (wrN),
    .cpuAddr (cpuAddr),
    .cpuData (cpuData),
    .regs    (regIf.regs),
    .dmaAddr (dmaAddr)
  );

endmodule

//--- verilog/dmaCtl_defs.svh
`ifndef DMA_CTL_DEFS_SVH
`define DMA_CTL_DEFS_SVH

// Register map widths of the 8237
`define DMA_CHANNELS 4
`define DMA_ADDR_W   16
`define DMA_DATA_W   8
`define DMA_COUNT_W  16

// CPU register addresses
// Channel n base address sits at 2n and its word count at 2n+1
`define DMA_REG_CMD   4'd8
`define DMA_REG_MASK  4'd10
`define DMA_REG_MODE  4'd11
`define DMA_REG_CLRFF 4'd12

`endif

//--- verilog/dmaIfs.sv
`timescale 1ns/1ps
`include "dmaCtl_defs.svh"

// Handshake between the control FSM and the arbiter
interface dmaSigIf
  import dmaPkg::*;
();
  logic    anyReq;
  channelT grantChan;
  logic    latchGrant;
  logic    serviceDone;

  modport control (
    input  anyReq,
    output latchGrant,
    output serviceDone
  );

  modport prio (
    output anyReq,
    output grantChan,
    input  latchGrant,
    input  serviceDone
  );
endinterface

// Register file view shared by control and arbitration
interface dmaRegIf
  import dmaPkg::*;
();
  logic [`DMA_CHANNELS-1:0] maskBits;
  logic                     rotatePriority;
  modeRegT                  grantMode;
  logic [`DMA_ADDR_W-1:0]   curAddr;
  logic                     tcReached;
  channelT                  grantChan;
  logic                     updateStrobe;

  modport regs (
    output maskBits,
    output rotatePriority,
    output grantMode,
    output curAddr,
    output tcReached,
    input  grantChan,
    input  updateStrobe
  );

  modport control (
    input  grantMode,
    input  tcReached,
    output updateStrobe
  );

  modport prio (
    input  maskBits,
    input  rotatePriority,
    output grantChan
  );
endinterface

//--- verilog/dmaPkg.sv
`include "dmaCtl_defs.svh"

package dmaPkg;

  // Direction as seen from memory
  typedef enum logic [1:0] {
    verifyXfer = 2'd0,
    writeXfer  = 2'd1,
    readXfer   = 2'd2
  } transferTypeT;

  typedef struct packed {
    transferTypeT transferType;
    logic         autoInit;
    logic         addrDecrement;
  } modeRegT;

  typedef logic [$clog2(`DMA_CHANNELS)-1:0] channelT;

endpackage

//--- verilog/dmaRegisters.sv
`timescale 1ns/1ps
`include "dmaCtl_defs.svh"

module dmaRegisters
  import dmaPkg::*;
(
  input  logic                   TCcpuIf,
  input  logic                   rstN,
  input  logic                   csN,
  input  logic                   wrN,
  input  logic [3:0]             cpuAddr,
  input  logic [`DMA_DATA_W-1:0] cpuData,
  dmaRegIf.regs                  regs,
  output logic [`DMA_ADDR_W-1:0] dmaAddr
);

  logic [`DMA_ADDR_W-1:0]   baseAddr  [`DMA_CHANNELS];
  logic [`DMA_ADDR_W-1:0]   curAddrR  [`DMA_CHANNELS];
  logic [`DMA_COUNT_W-1:0]  baseCount [`DMA_CHANNELS];
  logic [`DMA_COUNT_W-1:0]  curCount  [`DMA_CHANNELS];
  modeRegT                  modeR     [`DMA_CHANNELS];
  logic [`DMA_CHANNELS-1:0] maskR;
  logic                     rotateR;
  logic                     bytePtr;
  logic                     cpuWrite;
  logic                     chanWrite;
  channelT                  wrChan;
  channelT                  selChan;
  channelT                  gChan;

  assign cpuWrite  = !csN && !wrN;
  // Addresses 0 to 7 hold the per-channel address and count pairs
  assign chanWrite = cpuWrite && !cpuAddr[3];
  assign wrChan    = cpuAddr[2:1];
  assign selChan   = cpuData[1:0];
  assign gChan     = regs.grantChan;

  always_ff @(posedge TCcpuIf)
  begin
    if (regs.updateStrobe)
    begin
      if (regs.tcReached && modeR[gChan].autoInit)
      begin
        curAddrR[gChan] <= baseAddr[gChan];
        curCount[gChan] <= baseCount[gChan];
      end
      else
      begin
        if (modeR[gChan].addrDecrement)
          curAddrR[gChan] <= curAddrR[gChan] - 1'b1;
        else
          curAddrR[gChan] <= curAddrR[gChan] + 1'b1;
        curCount[gChan] <= curCount[gChan] - 1'b1;
      end
    end

    // Low byte first, then high byte, into both base and current
    if (chanWrite)
    begin
      if (cpuAddr[0])
      begin
        baseCount[wrChan][bytePtr * `DMA_DATA_W +: `DMA_DATA_W] <= cpuData;
        curCount[wrChan][bytePtr * `DMA_DATA_W +: `DMA_DATA_W]  <= cpuData;
      end
      else
      begin
        baseAddr[wrChan][bytePtr * `DMA_DATA_W +: `DMA_DATA_W] <= cpuData;
        curAddrR[wrChan][bytePtr * `DMA_DATA_W +: `DMA_DATA_W] <= cpuData;
      end
    end

    if (cpuWrite && cpuAddr == `DMA_REG_MODE)
      modeR[selChan] <= '{
        transferType:  transferTypeT'(cpuData[3:2]),
        autoInit:      cpuData[4],
        addrDecrement: cpuData[5]
      };
  end

  always_ff @(posedge TCcpuIf)
  begin
    if (!rstN)
    begin
      maskR   <= '1;
      rotateR <= 1'b0;
      bytePtr <= 1'b0;
    end
    else
    begin
      // Channel shuts itself off at terminal count
      if (regs.updateStrobe && regs.tcReached && !modeR[gChan].autoInit)
        maskR[gChan] <= 1'b1;
      if (cpuWrite)
      begin
        case (cpuAddr)
          `DMA_REG_CMD:   rotateR <= cpuData[4];
          `DMA_REG_MASK:  maskR[selChan] <= cpuData[2];
          `DMA_REG_CLRFF: bytePtr <= 1'b0;
          default:
            if (!cpuAddr[3])
              bytePtr <= !bytePtr;
        endcase
      end
    end
  end

  assign regs.maskBits       = maskR;
  assign regs.rotatePriority = rotateR;
  assign regs.grantMode      = modeR[gChan];
  assign regs.tcReached      = curCount[gChan] == '0;
  assign dmaAddr             = curAddrR[gChan];
  assign regs.curAddr        = dmaAddr;

endmodule

//--- verilog/priorityLogic.sv
`timescale 1ns/1ps
`include "dmaCtl_defs.svh"

module priorityLogic
  import dmaPkg::*;
(
  input  logic                     TCcpuIf,
  input  logic                     rstN,
  input  logic [`DMA_CHANNELS-1:0] dreq,
  dmaSigIf.prio                    sig,
  dmaRegIf.prio                    regs,
  output logic [`DMA_CHANNELS-1:0] dack
);

  logic [`DMA_CHANNELS-1:0] activeReq;
  channelT                  topPrio;
  channelT                  firstChan;
  channelT                  winner;
  channelT                  grantReg;

  assign activeReq = dreq & ~regs.maskBits;
  assign sig.anyReq = |activeReq;

  // Fixed priority always starts the search at channel 0
  assign firstChan = regs.rotatePriority ? topPrio : '0;

  always_comb
  begin : pickWinner
    channelT idx;
    logic    found;
    winner = firstChan;
    found  = 1'b0;
    for (int i = 0; i < `DMA_CHANNELS; i++)
    begin
      idx = firstChan + channelT'(i);
      if (!found && activeReq[idx])
      begin
        winner = idx;
        found  = 1'b1;
      end
    end
  end

  assign sig.grantChan  = winner;
  assign regs.grantChan = grantReg;

  always_ff @(posedge TCcpuIf)
  begin
    if (!rstN)
    begin
      grantReg <= '0;
      topPrio  <= '0;
      dack     <= '0;
    end
    else if (sig.latchGrant)
    begin
      grantReg <= winner;
      dack     <= {{(`DMA_CHANNELS-1){1'b0}}, 1'b1} << winner;
    end
    else if (sig.serviceDone)
    begin
      dack    <= '0;
      // Serviced channel drops to lowest priority
      topPrio <= grantReg + 1'b1;
    end
  end

endmodule

//--- verilog/timingAndControl.sv
`timescale 1ns/1ps

module timingAndControl
  import dmaPkg::*;
(
  input  logic     TCcpuIf,
  input  logic     rstN,
  input  logic     hlda,
  dmaSigIf.control sig,
  dmaRegIf.control regs,
  output logic     hrq,
  output logic     aen,
  output logic     adstb,
  output logic     memrN,
  output logic     memwN,
  output logic     iorN,
  output logic     iowN,
  output logic     eopN
);

  localparam int SiIdx = 0;
  localparam int S0Idx = 1;
  localparam int S1Idx = 2;
  localparam int S2Idx = 3;
  localparam int S3Idx = 4;
  localparam int S4Idx = 5;

  typedef enum logic [5:0] {
    SI = 6'b000001 << SiIdx,
    S0 = 6'b000001 << S0Idx,
    S1 = 6'b000001 << S1Idx,
    S2 = 6'b000001 << S2Idx,
    S3 = 6'b000001 << S3Idx,
    S4 = 6'b000001 << S4Idx
  } stateT;

  stateT state;
  stateT nextState;
  logic  xferCycle;
  logic  isWrite;
  logic  isRead;

  always_comb
  begin
    nextState = state;
    unique case (1'b1)
      state[SiIdx]:
        if (sig.anyReq)
          nextState = S0;
      // Request withdrawn before the bus was granted
      state[S0Idx]:
        if (!sig.anyReq)
          nextState = SI;
        else if (hlda)
          nextState = S1;
      state[S1Idx]: nextState = S2;
      state[S2Idx]: nextState = S3;
      state[S3Idx]: nextState = S4;
      state[S4Idx]: nextState = SI;
      default: nextState = SI;
    endcase
  end

  // Arbiter captures the winner on the edge into S1
  assign sig.latchGrant = state[S0Idx] & sig.anyReq & hlda;

  assign xferCycle = nextState[S2Idx] | nextState[S3Idx];
  assign isWrite   = regs.grantMode.transferType == writeXfer;
  assign isRead    = regs.grantMode.transferType == readXfer;

  // Outputs are decoded from the next state so they change with the state register
  always_ff @(posedge TCcpuIf)
  begin
    if (!rstN)
    begin
      state             <= SI;
      hrq               <= 1'b0;
      aen               <= 1'b0;
      adstb             <= 1'b0;
      memrN             <= 1'b1;
      memwN             <= 1'b1;
      iorN              <= 1'b1;
      iowN              <= 1'b1;
      eopN              <= 1'b1;
      regs.updateStrobe <= 1'b0;
      sig.serviceDone   <= 1'b0;
    end
    else
    begin
      state             <= nextState;
      hrq               <= !nextState[SiIdx];
      aen               <= nextState[S1Idx] | xferCycle | nextState[S4Idx];
      adstb             <= nextState[S1Idx];
      iorN              <= !(xferCycle && isWrite);
      memwN             <= !(xferCycle && isWrite);
      memrN             <= !(xferCycle && isRead);
      iowN              <= !(xferCycle && isRead);
      eopN              <= !(nextState[S4Idx] && regs.tcReached);
      regs.updateStrobe <= nextState[S4Idx];
      sig.serviceDone   <= nextState[S4Idx];
    end
  end

endmodule
